// ==== Makefile ====
# Verilator build and run of the FP ALU testbench

SIM      ?= verilator
SIMFLAGS ?= --binary --timing
TOP      ?= fp_alu_tb
FILELIST ?= sources.f
OBJDIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run the testbench, fail unless it passes"
	@echo "  clean  remove the build directory"

test:
	$(SIM) $(SIMFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "all tests passed"

clean:
	rm -rf $(OBJDIR)

// ==== design/fp_addsub_unit.sv ====
// shared add/subtract datapath: align, add or subtract, normalize, then saturate or flush
`timescale 1ns/10ps

module fp_addsub_unit import fp_alu_pkg::*; (
    fp_operand_if.unit opnd,
    output fp_word_t   sum
);

    logic               sign_b_eff;    // b sign after the subtract flip
    logic               a_big;         // a has the larger or equal magnitude
    logic               sign_big;
    fp_exp_t            exp_big;
    fp_exp_t            exp_diff;
    fp_sig_t            sig_big;
    fp_sig_t            sig_small;
    fp_sig_t            sig_aligned;
    logic [SIG_WIDTH:0] raw;           // sum or difference of significands
    fp_sig_t            norm;
    logic [4:0]         shift;
    int                 exp_res;

    assign sign_b_eff = (opnd.op == OP_SUB) ? ~opnd.sign_b : opnd.sign_b;

    // exponent first, then mantissa, ties go to a
    assign a_big = {opnd.exp_a, opnd.mant_a} >= {opnd.exp_b, opnd.mant_b};

    assign sign_big  = a_big ? opnd.sign_a : sign_b_eff;
    assign exp_big   = a_big ? opnd.exp_a : opnd.exp_b;
    assign exp_diff  = a_big ? opnd.exp_a - opnd.exp_b : opnd.exp_b - opnd.exp_a;
    assign sig_big   = a_big ? {1'b1, opnd.mant_a} : {1'b1, opnd.mant_b};
    assign sig_small = a_big ? {1'b1, opnd.mant_b} : {1'b1, opnd.mant_a};

    // bits shifted off the bottom are lost
    assign sig_aligned = (exp_diff >= SIG_WIDTH) ? '0 : sig_small >> exp_diff;

    assign raw = (opnd.sign_a == sign_b_eff) ? {1'b0, sig_big} + {1'b0, sig_aligned}
                                             : {1'b0, sig_big} - {1'b0, sig_aligned};

    fp_normalize normalize_inst (
        .diff  (raw),
        .norm  (norm),
        .shift (shift)
    );

    always_comb begin
        exp_res = int'(exp_big) + int'(raw[SIG_WIDTH]) - int'(shift);

        if (raw == '0) begin
            sum = '0;                                                // exact cancellation
        end else if (exp_res >= EXP_INF) begin
            sum = {sign_big, fp_exp_t'(EXP_INF), fp_mant_t'(0)};    // overflow to infinity
        end else if (exp_res < 1) begin
            sum = {sign_big, fp_exp_t'(0), fp_mant_t'(0)};          // flush, sign kept
        end else begin
            sum = {sign_big, fp_exp_t'(exp_res), norm[MANT_WIDTH-1:0]};
        end
    end

endmodule

// ==== design/fp_alu.sv ====
// top level of the two-stage floating-point ALU, operand stage, units and result register
`timescale 1ns/10ps

module fp_alu import fp_alu_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     in_valid,
    input  alu_op_t  op,
    input  fp_word_t a,
    input  fp_word_t b,
    output logic     out_valid,
    output fp_word_t result
);

    fp_word_t sum;
    fp_word_t product;

    fp_operand_if opnd_if ();

    fp_operand_stage operand_stage_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_valid (in_valid),
        .op       (op),
        .a        (a),
        .b        (b),
        .opnd     (opnd_if)
    );

    fp_addsub_unit addsub_inst (
        .opnd (opnd_if),
        .sum  (sum)
    );

    fp_mul_unit mul_inst (
        .opnd    (opnd_if),
        .product (product)
    );

    fp_result_select result_select_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .opnd      (opnd_if),
        .sum       (sum),
        .product   (product),
        .out_valid (out_valid),
        .result    (result)
    );

endmodule

// ==== design/fp_alu_pkg.sv ====
// format widths, exponent constants, op codes and field types shared by the FP ALU and its testbench
package fp_alu_pkg;

    localparam int WORD_WIDTH = 32;
    localparam int EXP_WIDTH  = 8;
    localparam int MANT_WIDTH = 23;
    localparam int SIG_WIDTH  = 24;     // mantissa plus hidden one
    localparam int OP_WIDTH   = 3;

    localparam int EXP_BIAS = 127;
    localparam int EXP_INF  = 255;      // saturated exponent, written with a zero mantissa

    typedef logic [WORD_WIDTH-1:0] fp_word_t;
    typedef logic [EXP_WIDTH-1:0]  fp_exp_t;
    typedef logic [MANT_WIDTH-1:0] fp_mant_t;
    typedef logic [SIG_WIDTH-1:0]  fp_sig_t;
    typedef logic [OP_WIDTH-1:0]   alu_op_t;

    // op codes, same numbering as the original combinational ALU
    localparam alu_op_t OP_ADD      = 3'd0;
    localparam alu_op_t OP_SUB      = 3'd1;
    localparam alu_op_t OP_MUL      = 3'd2;
    localparam alu_op_t OP_DIV_RSVD = 3'd3;   // divide removed, returns zero
    localparam alu_op_t OP_MIN      = 3'd4;
    localparam alu_op_t OP_MAX      = 3'd5;
    localparam alu_op_t OP_PASS_A   = 3'd6;
    localparam alu_op_t OP_PASS_A2  = 3'd7;

endpackage

// ==== design/fp_mul_unit.sv ====
// multiply datapath: significand product, exponent sum, one-bit renormalization and range clamp
`timescale 1ns/10ps

module fp_mul_unit import fp_alu_pkg::*; (
    fp_operand_if.unit opnd,
    output fp_word_t   product
);

    logic                   sign;
    fp_sig_t                sig_a;
    fp_sig_t                sig_b;
    logic [2*SIG_WIDTH-1:0] prod;
    logic                   carry;     // product of two 1.x values reached 2.0
    fp_mant_t               mant;
    int                     exp_res;

    assign sign  = opnd.sign_a ^ opnd.sign_b;
    assign sig_a = {1'b1, opnd.mant_a};
    assign sig_b = {1'b1, opnd.mant_b};
    assign prod  = {{SIG_WIDTH{1'b0}}, sig_a} * {{SIG_WIDTH{1'b0}}, sig_b};
    assign carry = prod[2*SIG_WIDTH-1];

    // truncate below the kept 23 bits
    assign mant = carry ? prod[2*SIG_WIDTH-2 -: MANT_WIDTH]
                        : prod[2*SIG_WIDTH-3 -: MANT_WIDTH];

    always_comb begin
        exp_res = int'(opnd.exp_a) + int'(opnd.exp_b) - EXP_BIAS + int'(carry);

        if (exp_res >= EXP_INF) begin
            product = {sign, fp_exp_t'(EXP_INF), fp_mant_t'(0)};
        end else if (exp_res < 1) begin
            product = {sign, fp_exp_t'(0), fp_mant_t'(0)};   // signed zero
        end else begin
            product = {sign, fp_exp_t'(exp_res), mant};
        end
    end

endmodule

// ==== design/fp_normalize.sv ====
// leading-one detector and shifter that puts an add/subtract magnitude back in 1.x form
`timescale 1ns/10ps

module fp_normalize import fp_alu_pkg::*; (
    input  logic [SIG_WIDTH:0] diff,   // magnitude with carry bit on top
    output fp_sig_t            norm,
    output logic [4:0]         shift   // places the leading one sits below the hidden bit
);

    always_comb begin
        shift = 5'd0;
        // ascending scan, so the highest set bit wins
        for (int i = 0; i < SIG_WIDTH; i++) begin
            if (diff[i]) begin
                shift = 5'(SIG_WIDTH - 1 - i);
            end
        end

        if (diff[SIG_WIDTH]) begin
            // carry out of an add, one place right and no left shift
            norm  = diff[SIG_WIDTH:1];
            shift = 5'd0;
        end else begin
            norm = diff[SIG_WIDTH-1:0] << shift;
        end
    end

endmodule

// ==== design/fp_operand_if.sv ====
// operand fields, op code and valid strobe passed from the operand stage to the ALU units
`timescale 1ns/10ps

interface fp_operand_if import fp_alu_pkg::*; ();

    logic     sign_a;
    fp_exp_t  exp_a;
    fp_mant_t mant_a;
    logic     sign_b;
    fp_exp_t  exp_b;
    fp_mant_t mant_b;
    alu_op_t  op;
    logic     valid;      // operation registered this cycle

    modport stage (
        output sign_a, exp_a, mant_a,
        output sign_b, exp_b, mant_b,
        output op, valid
    );

    modport unit (
        input sign_a, exp_a, mant_a,
        input sign_b, exp_b, mant_b,
        input op, valid
    );

endinterface

// ==== design/fp_operand_stage.sv ====
// first pipeline stage, registers the operands and op code and splits each operand into fields
`timescale 1ns/10ps

module fp_operand_stage import fp_alu_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        in_valid,
    input  alu_op_t     op,
    input  fp_word_t    a,
    input  fp_word_t    b,
    fp_operand_if.stage opnd
);

    fp_word_t a_q;
    fp_word_t b_q;
    alu_op_t  op_q;
    logic     valid_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= in_valid;
        end
    end

    // payload captured every cycle, qualified downstream by valid
    always_ff @(posedge clk) begin
        a_q  <= a;
        b_q  <= b;
        op_q <= op;
    end

    assign opnd.sign_a = a_q[WORD_WIDTH-1];
    assign opnd.exp_a  = a_q[WORD_WIDTH-2 -: EXP_WIDTH];
    assign opnd.mant_a = a_q[MANT_WIDTH-1:0];
    assign opnd.sign_b = b_q[WORD_WIDTH-1];
    assign opnd.exp_b  = b_q[WORD_WIDTH-2 -: EXP_WIDTH];
    assign opnd.mant_b = b_q[MANT_WIDTH-1:0];
    assign opnd.op     = op_q;
    assign opnd.valid  = valid_q;

endmodule

// ==== design/fp_result_select.sv ====
// second pipeline stage, min/max ordering, op-code mux and the registered result with its valid
`timescale 1ns/10ps

module fp_result_select import fp_alu_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    fp_operand_if.unit opnd,
    input  fp_word_t   sum,
    input  fp_word_t   product,
    output logic       out_valid,
    output fp_word_t   result
);

    fp_word_t a_word;
    fp_word_t b_word;
    logic     mag_gt;     // |a| > |b|
    logic     mag_lt;     // |a| < |b|
    logic     a_gt_b;     // a strictly greater as a signed value
    logic     b_gt_a;     // b strictly greater as a signed value
    fp_word_t min_word;
    fp_word_t max_word;
    fp_word_t sel;

    assign a_word = {opnd.sign_a, opnd.exp_a, opnd.mant_a};
    assign b_word = {opnd.sign_b, opnd.exp_b, opnd.mant_b};

    assign mag_gt = a_word[WORD_WIDTH-2:0] > b_word[WORD_WIDTH-2:0];
    assign mag_lt = a_word[WORD_WIDTH-2:0] < b_word[WORD_WIDTH-2:0];

    // positive beats negative, two negatives order by smaller magnitude
    assign a_gt_b = (opnd.sign_a != opnd.sign_b) ? ~opnd.sign_a
                  : (opnd.sign_a ? mag_lt : mag_gt);
    assign b_gt_a = (opnd.sign_a != opnd.sign_b) ? ~opnd.sign_b
                  : (opnd.sign_a ? mag_gt : mag_lt);

    assign max_word = b_gt_a ? b_word : a_word;          // equal values give a
    assign min_word = a_gt_b ? b_word : a_word;          // equal values give a

    always_comb begin
        case (opnd.op)
            OP_ADD, OP_SUB:        sel = sum;
            OP_MUL:                sel = product;
            OP_DIV_RSVD:           sel = '0;
            OP_MIN:                sel = min_word;
            OP_MAX:                sel = max_word;
            OP_PASS_A, OP_PASS_A2: sel = a_word;
            default:               sel = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            result    <= '0;
        end else begin
            out_valid <= opnd.valid;
            if (opnd.valid) begin
                result <= sel;         // holds the last result between operations
            end
        end
    end

endmodule

// ==== include/fp_alu_model.svh ====
// reference model functions for each ALU operation, included by the testbench after the package import
`ifndef FP_ALU_MODEL_SVH
`define FP_ALU_MODEL_SVH

function automatic fp_word_t pack_word(logic sign, int exp, fp_mant_t mant);
    if (exp >= EXP_INF) return {sign, fp_exp_t'(EXP_INF), fp_mant_t'(0)};
    if (exp < 1) return {sign, fp_exp_t'(0), fp_mant_t'(0)};
    return {sign, fp_exp_t'(exp), mant};
endfunction

function automatic fp_word_t add_or_sub(fp_word_t a, fp_word_t b, logic is_sub);
    fp_word_t b_eff;
    fp_word_t big;
    fp_word_t little;
    int       dexp;
    int       mag;
    int       exp;
    b_eff  = {b[31] ^ is_sub, b[30:0]};
    big    = (a[30:0] >= b[30:0]) ? a : b_eff;
    little = (a[30:0] >= b[30:0]) ? b_eff : a;
    dexp   = int'(big[30:23]) - int'(little[30:23]);
    exp    = int'(big[30:23]);
    mag    = (dexp >= SIG_WIDTH) ? 0 : int'({1'b1, little[22:0]}) >> dexp;
    if (big[31] == little[31]) mag = int'({1'b1, big[22:0]}) + mag;
    else mag = int'({1'b1, big[22:0]}) - mag;
    if (mag == 0) return '0;
    while (mag >= (1 << SIG_WIDTH)) begin
        mag = mag >> 1;
        exp = exp + 1;
    end
    while (mag < (1 << MANT_WIDTH)) begin
        mag = mag << 1;
        exp = exp - 1;
    end
    return pack_word(big[31], exp, fp_mant_t'(mag));
endfunction

function automatic fp_word_t multiply(fp_word_t a, fp_word_t b);
    logic [47:0] prod;
    int          exp;
    prod = {24'd0, 1'b1, a[22:0]} * {24'd0, 1'b1, b[22:0]};
    exp  = int'(a[30:23]) + int'(b[30:23]) - EXP_BIAS + int'(prod[47]);
    return pack_word(a[31] ^ b[31], exp, prod[47] ? prod[46:24] : prod[45:23]);
endfunction

function automatic logic is_greater(fp_word_t a, fp_word_t b);
    if (a[31] != b[31]) return !a[31];
    return a[31] ? (a[30:0] < b[30:0]) : (a[30:0] > b[30:0]);
endfunction

function automatic fp_word_t expected_result(alu_op_t op, fp_word_t a, fp_word_t b);
    case (op)
        OP_ADD:                return add_or_sub(a, b, 1'b0);
        OP_SUB:                return add_or_sub(a, b, 1'b1);
        OP_MUL:                return multiply(a, b);
        OP_MIN:                return is_greater(a, b) ? b : a;
        OP_MAX:                return (is_greater(b, a)) ? b : a;
        OP_PASS_A, OP_PASS_A2: return a;
        default:               return '0;
    endcase
endfunction

`endif

// ==== sim/fp_alu_tb.sv ====
// testbench for the FP ALU, drives LFSR operands and checks each result against the model
`timescale 1ns/10ps

module fp_alu_tb import fp_alu_pkg::*; ();

    `include "fp_alu_model.svh"

    logic     clk = 1'b0;
    logic     rst_n;
    logic     in_valid;
    alu_op_t  op;
    fp_word_t a;
    fp_word_t b;
    logic     out_valid;
    fp_word_t result;

    logic [31:0] lfsr = 32'h17a5_9bb0;
    int          cycle = 0;          // rising edges seen so far
    fp_word_t    exp_q[$];           // expected results in issue order
    int          due_q[$];           // cycle at which each result must show up
    string       test_name;
    int          errors = 0;
    int          total_errors = 0;
    int          tests_run = 0;
    int          tests_failed = 0;

    fp_alu fp_alu_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .op        (op),
        .a         (a),
        .b         (b),
        .out_valid (out_valid),
        .result    (result)
    );

    always #50 clk = ~clk;

    always @(posedge clk) cycle = cycle + 1;

    // Galois LFSR, one step per bit handed out
    function automatic logic [31:0] next_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = {1'b0, lfsr[31:1]} ^ (lfsr[0] ? 32'h8020_0003 : 32'h0);
        end
        return v;
    endfunction

    function automatic fp_word_t rand_operand();
        logic [31:0] s;
        logic [31:0] e;
        logic [31:0] m;
        s = next_bits(1);
        e = 32'd100 + next_bits(6) % 32'd55;   // exponent 100 to 154
        m = next_bits(23);
        return {s[0], e[7:0], m[22:0]};
    endfunction

    task automatic issue(alu_op_t o, fp_word_t x, fp_word_t y, fp_word_t expected);
        in_valid = 1'b1;
        op       = o;
        a        = x;
        b        = y;
        exp_q.push_back(expected);
        due_q.push_back(cycle + 2);        // result register loads two edges later
        @(posedge clk);
        #1;
    endtask

    task automatic issue_random(alu_op_t o);
        fp_word_t x;
        fp_word_t y;
        x = rand_operand();
        y = rand_operand();
        issue(o, x, y, expected_result(o, x, y));
    endtask

    task automatic drain();
        int waited;
        waited   = 0;
        in_valid = 1'b0;
        while (exp_q.size() != 0 && waited < 20) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (exp_q.size() != 0) begin
            $display("error in %s: timed out waiting for out_valid, %0d results missing",
                     test_name, exp_q.size());
            errors++;
            exp_q.delete();
            due_q.delete();
        end
        repeat (3) begin
            @(posedge clk);            // any stray out_valid here is caught by the monitor
            #1;
        end
    endtask

    task automatic end_test();
        drain();
        tests_run++;
        if (errors == 0) begin
            $display("test %s: ok", test_name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", test_name, errors);
        end
        total_errors += errors;
        errors = 0;
    endtask

    // outputs sampled on the falling edge, well away from the register updates
    always @(negedge clk) begin : monitor
        fp_word_t expected;
        int       due;
        if (rst_n && out_valid) begin
            if (exp_q.size() == 0) begin
                $display("error in %s: out_valid high with no operation outstanding", test_name);
                errors++;
            end else begin
                expected = exp_q.pop_front();
                due      = due_q.pop_front();
                if (cycle != due) begin
                    $display("Mismatch in %s: arrival cycle expected %0d, actual %0d",
                             test_name, due, cycle);
                    errors++;
                end
                if (result !== expected) begin
                    $display("Mismatch in %s: expected %h, actual %h", test_name, expected, result);
                    errors++;
                end
            end
        end
    end

    initial begin
        logic [31:0] r;
        fp_word_t    x;
        rst_n    = 1'b0;
        in_valid = 1'b0;
        op       = OP_ADD;
        a        = '0;
        b        = '0;
        repeat (10) @(posedge clk);
        #1;
        rst_n = 1'b1;

        test_name = "reset";
        if (out_valid !== 1'b0) begin
            $display("Mismatch in %s: out_valid expected 0, actual %b", test_name, out_valid);
            errors++;
        end
        if (result !== '0) begin
            $display("Mismatch in %s: expected %h, actual %h", test_name, 32'h0, result);
            errors++;
        end
        end_test();

        test_name = "add_sub";
        issue(OP_ADD, 32'h3f80_0000, 32'h3f80_0000, 32'h4000_0000);   // 1 + 1 = 2
        issue(OP_SUB, 32'h4040_0000, 32'h3f80_0000, 32'h4000_0000);   // 3 - 1 = 2
        for (int i = 0; i < 10; i++) begin
            x = rand_operand();
            issue(OP_SUB, x, x, 32'h0);                               // exact cancellation is +0
            issue(OP_ADD, x, {~x[31], x[30:0]}, 32'h0);
        end
        for (int i = 0; i < 200; i++) issue_random(OP_ADD);
        for (int i = 0; i < 200; i++) issue_random(OP_SUB);
        end_test();

        test_name = "multiply";
        issue(OP_MUL, 32'h4000_0000, 32'h4040_0000, 32'h40c0_0000);   // 2 * 3 = 6
        issue(OP_MUL, 32'h7f00_0000, 32'h7f00_0000, 32'h7f80_0000);   // overflow to +inf
        issue(OP_MUL, 32'hff00_0000, 32'h7f00_0000, 32'hff80_0000);
        issue(OP_MUL, 32'h0080_0000, 32'h8080_0000, 32'h8000_0000);   // underflow keeps sign
        for (int i = 0; i < 200; i++) issue_random(OP_MUL);
        end_test();

        test_name = "min_max_pass";
        issue(OP_MIN, 32'h4040_0000, 32'hc000_0000, 32'hc000_0000);
        issue(OP_MAX, 32'h4040_0000, 32'hc000_0000, 32'h4040_0000);
        issue(OP_MIN, 32'hc040_0000, 32'hc000_0000, 32'hc040_0000);   // two negatives
        for (int i = 0; i < 10; i++) begin
            x = rand_operand();
            issue(OP_MIN, x, x, x);
            issue(OP_MAX, x, x, x);
            issue(OP_PASS_A, x, rand_operand(), x);
            issue(OP_PASS_A2, x, rand_operand(), x);
            issue(OP_DIV_RSVD, x, rand_operand(), 32'h0);
        end
        for (int i = 0; i < 100; i++) begin
            issue_random(OP_MIN);
            issue_random(OP_MAX);
        end
        end_test();

        test_name = "pipeline_burst";
        for (int i = 0; i < 150; i++) begin
            r = next_bits(3);
            issue_random(r[2:0]);
        end
        end_test();

        $display("%0d tests run, %0d failing, %0d errors", tests_run, tests_failed, total_errors);
        if (tests_failed == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// ==== sources.f ====
+incdir+include
design/fp_alu_pkg.sv
design/fp_operand_if.sv
design/fp_operand_stage.sv
design/fp_normalize.sv
design/fp_addsub_unit.sv
design/fp_mul_unit.sv
design/fp_result_select.sv
design/fp_alu.sv
sim/fp_alu_tb.sv
